// ==== design/buffer_cfg_pkg.sv ====
// flit buffer sizing
`default_nettype none

package buffer_cfg_pkg;

    // number of buffer entries
    parameter int unsigned N_ENTRIES = 24;

    // flit payload width
    parameter int unsigned PAYLOAD_W = 128;

    // id width seen on each input port
    parameter int unsigned PORT_ID_W = 5;

    // same-id count, holds up to N_ENTRIES-1 older flits
    parameter int unsigned SEQ_W = 5;

endpackage

`default_nettype wire

// ==== design/flit_pkg.sv ====
// flit field types
`default_nettype none

package flit_pkg;

    typedef logic [buffer_cfg_pkg::PORT_ID_W:0] gid_t;  // port bit is the msb
    typedef logic [1:0]                          qos_t;  // 3 is the highest level
    typedef logic [3:0]                          qos_bin_t;

    typedef struct packed {
        gid_t                               gid;
        qos_t                               qos;
        logic [buffer_cfg_pkg::PAYLOAD_W-1:0] payload;
    } flit_t;

    function automatic qos_bin_t qos_to_bin(input qos_t qos);
        qos_to_bin = qos_bin_t'(1) << qos;
    endfunction

    // bin must be one-hot or zero
    function automatic qos_t bin_to_qos(input qos_bin_t bin);
        bin_to_qos = bin[3] ? 2'd3 : bin[2] ? 2'd2 : bin[1] ? 2'd1 : 2'd0;
    endfunction

endpackage

`default_nettype wire

// ==== design/buffer_ifs.sv ====
// buffer internal interfaces
`timescale 1ns/1ns
`default_nettype none

// ingress to table and payload store
interface write_if;
    logic                                 en;       // write happens at this edge
    flit_pkg::gid_t                       gid;
    flit_pkg::qos_t                       qos;
    logic [buffer_cfg_pkg::PAYLOAD_W-1:0] payload;

    modport src (output en, output gid, output qos, output payload);
    modport dst (input en, input gid, input qos, input payload);
endinterface

// table grant and retire strobe with egress
interface retire_if #(
    parameter int unsigned n_entries = 24
);
    logic [n_entries-1:0] grant;      // one-hot
    logic                 grant_vld;
    flit_pkg::gid_t       gid;
    flit_pkg::qos_t       qos;
    logic                 retire;     // granted entry leaves at this edge

    modport tbl (
        output grant, output grant_vld, output gid, output qos,
        input  retire
    );
    modport egress (
        input  grant, input grant_vld, input gid, input qos,
        output retire
    );
endinterface

`default_nettype wire

// ==== design/entry_slot.sv ====
// single buffer entry
`timescale 1ns/1ns
`default_nettype none

module entry_slot (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic                             i_load,
    input  wire flit_pkg::gid_t                   i_gid,          // write gid
    input  wire flit_pkg::qos_t                   i_qos,
    input  wire logic [buffer_cfg_pkg::SEQ_W-1:0] i_seq,
    input  wire logic                             i_retire_self,
    input  wire logic                             i_retire_match, // retire broadcast
    input  wire flit_pkg::gid_t                   i_cmp_gid,      // retiring gid
    output logic                                  o_valid,
    output logic                                  o_match,
    output logic                                  o_eligible,
    output flit_pkg::qos_bin_t                    o_qos_bin,
    output flit_pkg::gid_t                        o_gid
);

    logic                             valid;
    flit_pkg::gid_t                   gid;
    flit_pkg::qos_t                   qos;
    logic [buffer_cfg_pkg::SEQ_W-1:0] seq;   // older same-id flits still buffered
    logic                             dec;

    // an older flit of this id is leaving
    assign dec = valid & i_retire_match & (gid == i_cmp_gid) & (seq != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            seq   <= '0;
        end else if (i_load) begin
            valid <= 1'b1;
            seq   <= i_seq;
        end else begin
            if (i_retire_self)
                valid <= 1'b0;
            if (dec)
                seq <= seq - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            gid <= i_gid;
            qos <= i_qos;
        end
    end

    assign o_valid    = valid;
    assign o_match    = valid & (gid == i_gid);
    assign o_eligible = valid & (seq == '0);
    assign o_qos_bin  = valid ? flit_pkg::qos_to_bin(qos) : '0;
    assign o_gid      = gid;

endmodule

`default_nettype wire

// ==== design/qos_scheduler.sv ====
// qos priority scheduler
`timescale 1ns/1ns
`default_nettype none

module qos_scheduler #(
    parameter int unsigned n_entries = 24
) (
    input  wire logic [n_entries-1:0]               i_eligible,
    input  wire flit_pkg::qos_bin_t [n_entries-1:0] i_qos_bin,
    output logic [n_entries-1:0]                    o_grant,
    output logic                                    o_grant_vld
);

    flit_pkg::qos_bin_t present;   // levels held by eligible entries
    flit_pkg::qos_bin_t top;
    logic               found;

    always_comb begin
        present = '0;
        for (int i = 0; i < n_entries; i++) begin
            if (i_eligible[i])
                present = present | i_qos_bin[i];
        end
        top = present[3] ? 4'b1000 :
              present[2] ? 4'b0100 :
              present[1] ? 4'b0010 :
              present[0] ? 4'b0001 : 4'b0000;
    end

    // lowest index wins among the top level
    always_comb begin
        o_grant = '0;
        found   = 1'b0;
        for (int i = 0; i < n_entries; i++) begin
            if (!found && i_eligible[i] && |(i_qos_bin[i] & top)) begin
                o_grant[i] = 1'b1;
                found      = 1'b1;
            end
        end
    end

    assign o_grant_vld = |i_eligible;

endmodule

`default_nettype wire

// ==== design/entry_table.sv ====
// buffer entry table
`timescale 1ns/1ns
`default_nettype none

module entry_table #(
    parameter int unsigned n_entries = 24
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    write_if.dst             wr,
    retire_if.tbl            rt,
    output logic             o_not_full2,
    output logic [n_entries-1:0] o_wr_slot
);

    localparam int unsigned CNT_W = $clog2(n_entries + 1);

    logic [n_entries-1:0]                   valid;
    logic [n_entries-1:0]                   match;
    logic [n_entries-1:0]                   eligible;
    flit_pkg::qos_bin_t [n_entries-1:0]     qos_bin;
    flit_pkg::gid_t [n_entries-1:0]         slot_gid;
    logic [n_entries-1:0]                   grant;
    logic                                   grant_vld;
    logic                                   slot_found;
    logic [CNT_W-1:0]                       free_cnt;
    logic [buffer_cfg_pkg::SEQ_W-1:0]       match_cnt;
    logic [buffer_cfg_pkg::SEQ_W-1:0]       new_seq;
    logic                                   retire_same;
    flit_pkg::gid_t                         sel_gid;
    flit_pkg::qos_bin_t                     sel_bin;

    for (genvar i = 0; i < n_entries; i++) begin : g_slot
        entry_slot u_entry_slot (
            .clk            (clk),
            .rst_n          (rst_n),
            .i_load         (wr.en & o_wr_slot[i]),
            .i_gid          (wr.gid),
            .i_qos          (wr.qos),
            .i_seq          (new_seq),
            .i_retire_self  (rt.retire & grant[i]),
            .i_retire_match (rt.retire),
            .i_cmp_gid      (rt.gid),
            .o_valid        (valid[i]),
            .o_match        (match[i]),
            .o_eligible     (eligible[i]),
            .o_qos_bin      (qos_bin[i]),
            .o_gid          (slot_gid[i])
        );
    end

    qos_scheduler #(.n_entries(n_entries)) u_qos_scheduler (
        .i_eligible  (eligible),
        .i_qos_bin   (qos_bin),
        .o_grant     (grant),
        .o_grant_vld (grant_vld)
    );

    // lowest free slot plus free and same-id counts
    always_comb begin
        o_wr_slot  = '0;
        slot_found = 1'b0;
        free_cnt   = '0;
        match_cnt  = '0;
        for (int i = 0; i < n_entries; i++) begin
            if (!valid[i] && !slot_found) begin
                o_wr_slot[i] = 1'b1;
                slot_found   = 1'b1;
            end
            free_cnt  = free_cnt + CNT_W'(!valid[i]);
            match_cnt = match_cnt + buffer_cfg_pkg::SEQ_W'(match[i]);
        end
    end

    assign retire_same = rt.retire & (rt.gid == wr.gid);
    assign new_seq     = match_cnt - buffer_cfg_pkg::SEQ_W'(retire_same);

    // the write in flight already owns one of the free slots
    assign o_not_full2 = free_cnt >= CNT_W'(2 + wr.en);

    always_comb begin
        sel_gid = '0;
        sel_bin = '0;
        for (int i = 0; i < n_entries; i++) begin
            if (grant[i]) begin
                sel_gid = sel_gid | slot_gid[i];
                sel_bin = sel_bin | qos_bin[i];
            end
        end
    end

    assign rt.grant     = grant;
    assign rt.grant_vld = grant_vld;
    assign rt.gid       = sel_gid;
    assign rt.qos       = flit_pkg::bin_to_qos(sel_bin);

endmodule

`default_nettype wire

// ==== design/payload_store.sv ====
// payload storage array
`timescale 1ns/1ns
`default_nettype none

module payload_store #(
    parameter int unsigned n_entries = 24
) (
    input  wire logic                                 clk,
    write_if.dst                                      wr,
    input  wire logic [n_entries-1:0]                 i_wr_slot,
    input  wire logic [n_entries-1:0]                 i_rd_sel,   // one-hot
    output logic [buffer_cfg_pkg::PAYLOAD_W-1:0]      o_payload
);

    logic [buffer_cfg_pkg::PAYLOAD_W-1:0] mem [n_entries];

    for (genvar i = 0; i < n_entries; i++) begin : g_wr
        always_ff @(posedge clk) begin
            if (wr.en && i_wr_slot[i])
                mem[i] <= wr.payload;
        end
    end

    always_comb begin
        o_payload = '0;
        for (int i = 0; i < n_entries; i++)
            o_payload = o_payload | ({buffer_cfg_pkg::PAYLOAD_W{i_rd_sel[i]}} & mem[i]);
    end

endmodule

`default_nettype wire

// ==== design/ingress_arbiter.sv ====
// two port ingress arbiter
`timescale 1ns/1ns
`default_nettype none

module ingress_arbiter (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 i_valid_a,
    input  wire logic [buffer_cfg_pkg::PORT_ID_W-1:0] i_id_a,
    input  wire flit_pkg::qos_t                       i_qos_a,
    input  wire logic [buffer_cfg_pkg::PAYLOAD_W-1:0] i_payload_a,
    output logic                                      o_ready_a,
    input  wire logic                                 i_valid_b,
    input  wire logic [buffer_cfg_pkg::PORT_ID_W-1:0] i_id_b,
    input  wire flit_pkg::qos_t                       i_qos_b,
    input  wire logic [buffer_cfg_pkg::PAYLOAD_W-1:0] i_payload_b,
    output logic                                      o_ready_b,
    input  wire logic                                 i_not_full2,
    write_if.src                                      wr
);

    logic            port_sel;   // 0 selects a, 1 selects b
    logic            sel_next;
    logic            acc_a;
    logic            acc_b;
    logic            en_q;
    flit_pkg::flit_t flit_q;

    assign acc_a = i_valid_a & o_ready_a;
    assign acc_b = i_valid_b & o_ready_b;

    // flip when both ports want service or both are quiet
    assign sel_next = (i_valid_a == i_valid_b) ? ~port_sel : port_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            port_sel  <= 1'b0;
            o_ready_a <= 1'b1;
            o_ready_b <= 1'b0;
            en_q      <= 1'b0;
        end else begin
            port_sel  <= sel_next;
            o_ready_a <= ~sel_next & i_not_full2;
            o_ready_b <= sel_next & i_not_full2;
            en_q      <= acc_a | acc_b;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_a | acc_b) begin
            flit_q.gid     <= {acc_b, (acc_b ? i_id_b : i_id_a)};
            flit_q.qos     <= acc_b ? i_qos_b : i_qos_a;
            flit_q.payload <= acc_b ? i_payload_b : i_payload_a;
        end
    end

    assign wr.en      = en_q;
    assign wr.gid     = flit_q.gid;
    assign wr.qos     = flit_q.qos;
    assign wr.payload = flit_q.payload;

endmodule

`default_nettype wire

// ==== design/egress_stage.sv ====
// output register stage
`timescale 1ns/1ns
`default_nettype none

module egress_stage #(
    parameter int unsigned n_entries = 24
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    retire_if.egress                                  rt,
    input  wire logic [buffer_cfg_pkg::PAYLOAD_W-1:0] i_payload,
    input  wire logic                                 i_ready,
    output logic                                      o_valid,
    output flit_pkg::gid_t                            o_gid,
    output flit_pkg::qos_t                            o_qos,
    output logic [buffer_cfg_pkg::PAYLOAD_W-1:0]      o_payload
);

    logic load;

    // register free or draining this edge, and a real grant present
    assign load = rt.grant_vld & (rt.grant != {n_entries{1'b0}}) & (~o_valid | i_ready);

    assign rt.retire = load;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            o_valid <= 1'b0;
        else if (load)
            o_valid <= 1'b1;
        else if (i_ready)
            o_valid <= 1'b0;   // delivered, nothing to follow
    end

    always_ff @(posedge clk) begin
        if (load) begin
            o_gid     <= rt.gid;
            o_qos     <= rt.qos;
            o_payload <= i_payload;
        end
    end

endmodule

`default_nettype wire

// ==== design/flit_buffer_top.sv ====
// shared flit buffer top
`timescale 1ns/1ns
`default_nettype none

module flit_buffer_top #(
    parameter int unsigned n_entries = buffer_cfg_pkg::N_ENTRIES
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 i_valid_a,
    input  wire logic [buffer_cfg_pkg::PORT_ID_W-1:0] i_id_a,
    input  wire flit_pkg::qos_t                       i_qos_a,
    input  wire logic [buffer_cfg_pkg::PAYLOAD_W-1:0] i_payload_a,
    output logic                                      o_ready_a,
    input  wire logic                                 i_valid_b,
    input  wire logic [buffer_cfg_pkg::PORT_ID_W-1:0] i_id_b,
    input  wire flit_pkg::qos_t                       i_qos_b,
    input  wire logic [buffer_cfg_pkg::PAYLOAD_W-1:0] i_payload_b,
    output logic                                      o_ready_b,
    output logic                                      o_valid,
    output flit_pkg::gid_t                            o_gid,
    output flit_pkg::qos_t                            o_qos,
    output logic [buffer_cfg_pkg::PAYLOAD_W-1:0]      o_payload,
    input  wire logic                                 i_ready
);

    logic                                 not_full2;
    logic [n_entries-1:0]                 wr_slot;
    logic [buffer_cfg_pkg::PAYLOAD_W-1:0] rd_payload;

    write_if                          u_wr ();
    retire_if #(.n_entries(n_entries)) u_rt ();

    ingress_arbiter u_ingress_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_valid_a   (i_valid_a),
        .i_id_a      (i_id_a),
        .i_qos_a     (i_qos_a),
        .i_payload_a (i_payload_a),
        .o_ready_a   (o_ready_a),
        .i_valid_b   (i_valid_b),
        .i_id_b      (i_id_b),
        .i_qos_b     (i_qos_b),
        .i_payload_b (i_payload_b),
        .o_ready_b   (o_ready_b),
        .i_not_full2 (not_full2),
        .wr          (u_wr.src)
    );

    entry_table #(.n_entries(n_entries)) u_entry_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr          (u_wr.dst),
        .rt          (u_rt.tbl),
        .o_not_full2 (not_full2),
        .o_wr_slot   (wr_slot)
    );

    payload_store #(.n_entries(n_entries)) u_payload_store (
        .clk       (clk),
        .wr        (u_wr.dst),
        .i_wr_slot (wr_slot),
        .i_rd_sel  (u_rt.grant),
        .o_payload (rd_payload)
    );

    egress_stage #(.n_entries(n_entries)) u_egress_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .rt        (u_rt.egress),
        .i_payload (rd_payload),
        .i_ready   (i_ready),
        .o_valid   (o_valid),
        .o_gid     (o_gid),
        .o_qos     (o_qos),
        .o_payload (o_payload)
    );

endmodule

`default_nettype wire

// ==== bench/tb_flit_buffer.sv ====
// flit buffer testbench
`timescale 1ns/1ns
`default_nettype none

module tb_flit_buffer;

    localparam int N          = buffer_cfg_pkg::N_ENTRIES;
    localparam int ID_RANGE   = 4;             // small so ids repeat
    localparam int RAND_LEN   = 600;
    localparam int STALL_MAX  = 4 * N + 16;
    localparam int STALL_HOLD = 8;
    localparam int ALT_LEN    = 40;
    localparam int DRAIN_LEN  = 8 * N;
    localparam int STIM_LEN   = 16 + RAND_LEN + STALL_MAX + STALL_HOLD + ALT_LEN + 4;
    localparam int TIMEOUT    = 10 * STIM_LEN + 2 * DRAIN_LEN;

    typedef logic [buffer_cfg_pkg::PORT_ID_W-1:0] id_t;
    typedef logic [buffer_cfg_pkg::PAYLOAD_W-1:0] payload_t;

    logic           clk;
    logic           rst_n;
    logic           i_valid_a;
    id_t            i_id_a;
    flit_pkg::qos_t i_qos_a;
    payload_t       i_payload_a;
    logic           o_ready_a;
    logic           i_valid_b;
    id_t            i_id_b;
    flit_pkg::qos_t i_qos_b;
    payload_t       i_payload_b;
    logic           o_ready_b;
    logic           o_valid;
    flit_pkg::gid_t o_gid;
    flit_pkg::qos_t o_qos;
    payload_t       o_payload;
    logic           i_ready;

    flit_pkg::flit_t model_q[$];   // accepted and not yet delivered, oldest first
    int              cyc_q[$];     // acceptance cycle per model entry

    int   mon_errs  = 0;
    int   main_errs = 0;
    int   hold_errs = 0;
    int   excl_errs = 0;
    int   timeouts  = 0;
    int   cycle     = 0;
    int   stall_acc = 0;
    logic prev_valid   = 1'b0;
    logic prev_deliver = 1'b0;
    logic have_last    = 1'b0;
    logic last_b       = 1'b0;
    logic stall_phase  = 1'b0;
    logic stall_locked = 1'b0;
    logic alt_phase    = 1'b0;

    flit_buffer_top #(.n_entries(N)) u_flit_buffer_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_valid_a   (i_valid_a),
        .i_id_a      (i_id_a),
        .i_qos_a     (i_qos_a),
        .i_payload_a (i_payload_a),
        .o_ready_a   (o_ready_a),
        .i_valid_b   (i_valid_b),
        .i_id_b      (i_id_b),
        .i_qos_b     (i_qos_b),
        .i_payload_b (i_payload_b),
        .o_ready_b   (o_ready_b),
        .o_valid     (o_valid),
        .o_gid       (o_gid),
        .o_qos       (o_qos),
        .o_payload   (o_payload),
        .i_ready     (i_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // stalled output must not move
    assert property (@(posedge clk) disable iff (!rst_n)
        (o_valid && !i_ready) |=>
            (o_valid && $stable(o_gid) && $stable(o_qos) && $stable(o_payload)))
        else begin
            hold_errs++;
            $display("mismatch at %0t: output changed while stalled", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n) !(o_ready_a && o_ready_b))
        else begin
            excl_errs++;
            $display("mismatch at %0t: both readies high", $time);
        end

    // index of the oldest model flit with this gid, -1 if none
    function automatic int oldest_of(input flit_pkg::gid_t gid);
        for (int j = 0; j < model_q.size(); j++) begin
            if (model_q[j].gid == gid)
                return j;
        end
        return -1;
    endfunction

    function automatic void record_accept(input flit_pkg::gid_t gid,
                                          input flit_pkg::qos_t qos,
                                          input payload_t payload);
        flit_pkg::flit_t f;
        f.gid     = gid;
        f.qos     = qos;
        f.payload = payload;
        model_q.push_back(f);
        cyc_q.push_back(cycle);
    endfunction

    // head-of-id flits written before the grant must not outrank the new output
    task automatic check_priority();
        int own;
        own = oldest_of(o_gid);
        for (int j = 0; j < model_q.size(); j++) begin
            if (j != own && j == oldest_of(model_q[j].gid) && cyc_q[j] + 3 <= cycle) begin
                assert (o_qos >= model_q[j].qos) else begin
                    mon_errs++;
                    $display("mismatch at %0t: qos %0d sent while gid %0h qos %0d waited",
                             $time, o_qos, model_q[j].gid, model_q[j].qos);
                end
            end
        end
    endtask

    always @(posedge clk) begin : monitor
        int   hit;
        logic acc_a;
        logic acc_b;
        cycle = cycle + 1;
        acc_a = i_valid_a && o_ready_a;
        acc_b = i_valid_b && o_ready_b;
        if (rst_n) begin
            if (o_valid && (!prev_valid || prev_deliver))
                check_priority();
            if (o_valid && i_ready) begin
                hit = oldest_of(o_gid);
                assert (hit >= 0) else begin
                    mon_errs++;
                    $display("delivered flit with gid %0h was never accepted", o_gid);
                end
                if (hit >= 0) begin
                    assert (model_q[hit].qos == o_qos && model_q[hit].payload == o_payload)
                    else begin
                        mon_errs++;
                        $display("mismatch at %0t: gid %0h got qos %0d payload %h, want %0d %h",
                                 $time, o_gid, o_qos, o_payload,
                                 model_q[hit].qos, model_q[hit].payload);
                    end
                    model_q.delete(hit);
                    cyc_q.delete(hit);
                end
            end
            if (acc_a)
                record_accept({1'b0, i_id_a}, i_qos_a, i_payload_a);
            if (acc_b)
                record_accept({1'b1, i_id_b}, i_qos_b, i_payload_b);
            if (stall_phase && (acc_a || acc_b)) begin
                stall_acc = stall_acc + 1;
                assert (stall_acc <= N + 2) else begin
                    mon_errs++;
                    $display("too many flits accepted with the output stalled");
                end
                assert (!stall_locked) else begin
                    mon_errs++;
                    $display("flit accepted after both readies dropped");
                end
            end
            if (alt_phase && (acc_a || acc_b)) begin
                if (have_last) begin
                    assert (acc_b != last_b) else begin
                        mon_errs++;
                        $display("mismatch at %0t: port %s accepted twice in a row",
                                 $time, acc_b ? "b" : "a");
                    end
                end
                have_last = 1'b1;
                last_b    = acc_b;
            end
        end
        if (!stall_phase)
            stall_acc = 0;
        if (!alt_phase)
            have_last = 1'b0;
        prev_valid   = rst_n && o_valid;
        prev_deliver = rst_n && o_valid && i_ready;
    end

    // new flit only once the current one is taken
    task automatic drive_inputs(input int valid_pct, input int ready_pct);
        @(posedge clk);
        if (!i_valid_a || o_ready_a) begin
            i_valid_a   <= ($urandom % 100) < valid_pct;
            i_id_a      <= id_t'($urandom % ID_RANGE);
            i_qos_a     <= flit_pkg::qos_t'($urandom);
            i_payload_a <= payload_t'({$urandom, $urandom, $urandom, $urandom});
        end
        if (!i_valid_b || o_ready_b) begin
            i_valid_b   <= ($urandom % 100) < valid_pct;
            i_id_b      <= id_t'($urandom % ID_RANGE);
            i_qos_b     <= flit_pkg::qos_t'($urandom);
            i_payload_b <= payload_t'({$urandom, $urandom, $urandom, $urandom});
        end
        i_ready <= ($urandom % 100) < ready_pct;
    endtask

    task automatic drain_buffer();
        logic done;
        done = 1'b0;
        while (!done) begin
            drive_inputs(0, 100);
            @(negedge clk);
            done = (model_q.size() == 0) && !o_valid && !i_valid_a && !i_valid_b;
        end
    endtask

    task automatic finish_run();
        int total;
        total = mon_errs + main_errs + hold_errs + excl_errs + timeouts;
        $display("errors: %0d model, %0d sequence, %0d hold, %0d ready, %0d timeout",
                 mon_errs, main_errs, hold_errs, excl_errs, timeouts);
        if (total == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    endtask

    initial begin : watchdog
        int cnt;
        cnt = 0;
        while (cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        $display("run stopped after %0d cycles without finishing", cnt);
        timeouts = 1;
        finish_run();
    end

    initial begin : stimulus
        int n;
        void'($urandom(32'h5fa3));
        rst_n       = 1'b0;
        i_valid_a   = 1'b0;
        i_id_a      = '0;
        i_qos_a     = '0;
        i_payload_a = '0;
        i_valid_b   = 1'b0;
        i_id_b      = '0;
        i_qos_b     = '0;
        i_payload_b = '0;
        i_ready     = 1'b0;
        repeat (16) @(posedge clk);
        assert (!o_valid && o_ready_a && !o_ready_b) else begin
            main_errs++;
            $display("mismatch at %0t: reset state valid %b ready_a %b ready_b %b",
                     $time, o_valid, o_ready_a, o_ready_b);
        end
        rst_n <= 1'b1;

        for (int i = 0; i < RAND_LEN; i++)
            drive_inputs(60, (i < RAND_LEN / 2) ? 75 : 35);   // then build a backlog

        // hold the output until the buffer fills
        drive_inputs(100, 0);
        stall_phase <= 1'b1;
        n = 0;
        do begin
            drive_inputs(100, 0);
            @(negedge clk);
            n++;
        end while ((o_ready_a || o_ready_b) && n < STALL_MAX);
        assert (!o_ready_a && !o_ready_b) else begin
            main_errs++;
            $display("readies stayed high with the output stalled");
        end
        stall_locked <= 1'b1;
        repeat (STALL_HOLD) drive_inputs(100, 0);
        stall_phase  <= 1'b0;
        stall_locked <= 1'b0;
        drain_buffer();

        repeat (2) drive_inputs(100, 100);
        alt_phase <= 1'b1;
        repeat (ALT_LEN) drive_inputs(100, 100);
        alt_phase <= 1'b0;
        drain_buffer();

        assert (model_q.size() == 0) else begin
            main_errs++;
            $display("%0d accepted flits were never delivered", model_q.size());
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/buffer_cfg_pkg.sv
design/flit_pkg.sv
design/buffer_ifs.sv
design/entry_slot.sv
design/qos_scheduler.sv
design/entry_table.sv
design/payload_store.sv
design/ingress_arbiter.sv
design/egress_stage.sv
design/flit_buffer_top.sv
bench/tb_flit_buffer.sv

// ==== run.sh ====
#!/bin/bash
# build and run the flit buffer testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_flit_buffer -f verilog.f -o tb_flit_buffer \
    && ./obj_dir/tb_flit_buffer > sim.log 2>&1 \
    || { echo "build or simulation failed, see sim.log"; exit 1; }

grep -q "All tests passed!" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }
